// File: hdl/csiRxPkg.sv
package csiRxPkg;

  // lane and word geometry for the fixed two-lane link
  localparam int laneByteWidth = 8;
  localparam int laneWordWidth = 16;
  localparam int bytesPerWord = laneWordWidth / laneByteWidth;

  // header field widths
  localparam int dataTypeWidth = 6;
  localparam int virtualChannelWidth = 2;
  localparam int headerFieldWidth = 16;

  localparam logic [laneByteWidth-1:0] syncByte = 8'hB8;

  // short packet codes, anything else is treated as a long packet
  localparam logic [dataTypeWidth-1:0] dtFrameStart = 6'd0;
  localparam logic [dataTypeWidth-1:0] dtFrameEnd = 6'd1;

  localparam logic [headerFieldWidth-1:0] wordCountReset = '1;

  typedef enum logic [2:0] {
    huntSync,
    headerLow,
    headerHigh,
    payload,
    packetGap
  } parserState_t;

  // field high byte, field low byte, data identifier
  typedef struct packed {
    logic [headerFieldWidth-1:0] frameNumber;
    logic [virtualChannelWidth-1:0] virtualChannel;
    logic [dataTypeWidth-1:0] shortCode;
  } shortHeader_t;

  typedef struct packed {
    logic [headerFieldWidth-1:0] wordCount;
    logic [virtualChannelWidth-1:0] virtualChannel;
    logic [dataTypeWidth-1:0] dataType;
  } longHeader_t;

  typedef union packed {
    shortHeader_t shortPkt;
    longHeader_t longPkt;
  } packetHeader_t;

endpackage

// File: hdl/laneCapture.sv
`timescale 1ns/1ps

module laneCapture
  import csiRxPkg::*;
(
  input  logic                     CAM_CLOCK_I,
  input  logic                     RESET_n_I,
  input  logic [laneByteWidth-1:0] laneA_i,
  input  logic [laneByteWidth-1:0] laneB_i,
  output logic [laneWordWidth-1:0] laneWord_o,
  output logic                     syncHit_o
);

  logic syncNow;

  // both lanes must carry the sync byte in the same cycle
  assign syncNow = (laneA_i == syncByte) && (laneB_i == syncByte);

  // lane A is the lower byte of the word
  always_ff @(posedge CAM_CLOCK_I)
  begin
    laneWord_o <= {laneB_i, laneA_i};
  end

  // flag travels with the word it describes
  always_ff @(posedge CAM_CLOCK_I)
  begin
    if (!RESET_n_I)
    begin
      syncHit_o <= 1'b0;
    end
    else
    begin
      syncHit_o <= syncNow;
    end
  end

endmodule

// File: hdl/packetParser.sv
`timescale 1ns/1ps

module packetParser
  import csiRxPkg::*;
(
  input  logic                        CAM_CLOCK_I,
  input  logic                        RESET_n_I,
  input  logic [laneWordWidth-1:0]    laneWord_i,
  input  logic                        syncHit_i,
  output logic [laneWordWidth-1:0]    payloadWord_o,
  output logic                        payloadStrobe_o,
  output logic                        packetLast_o,
  output logic                        frameActive_o,
  output logic [headerFieldWidth-1:0] frameNumber_o,
  output logic [headerFieldWidth-1:0] wordCount_o
);

  parserState_t state;
  logic [laneWordWidth-1:0] headerLowWord;
  logic [headerFieldWidth-1:0] byteCount;
  logic [dataTypeWidth-1:0] firstDataType;
  packetHeader_t assembledHeader;

  // data type is decoded straight from the first header word
  assign firstDataType = laneWord_i[dataTypeWidth-1:0];

  // second header word supplies the field high byte, its upper byte is ECC
  assign assembledHeader = {laneWord_i[laneByteWidth-1:0], headerLowWord};

  always_ff @(posedge CAM_CLOCK_I)
  begin
    if (!RESET_n_I)
    begin
      state <= huntSync;
      payloadStrobe_o <= 1'b0;
      packetLast_o <= 1'b0;
      frameActive_o <= 1'b0;
      frameNumber_o <= '0;
      wordCount_o <= wordCountReset;
      byteCount <= '0;
    end
    else
    begin
      payloadStrobe_o <= 1'b0;
      packetLast_o <= 1'b0;
      case (state)
        // a sync right after the last payload word is accepted here too
        huntSync, packetGap:
        begin
          if (syncHit_i)
          begin
            state <= headerLow;
          end
          else
          begin
            state <= huntSync;
          end
        end
        headerLow:
        begin
          if (firstDataType == dtFrameEnd)
          begin
            frameActive_o <= 1'b0;
            state <= huntSync;
          end
          else
          begin
            if (firstDataType == dtFrameStart)
            begin
              frameActive_o <= 1'b1;
            end
            state <= headerHigh;
          end
        end
        headerHigh:
        begin
          if (assembledHeader.shortPkt.shortCode == dtFrameStart)
          begin
            frameNumber_o <= assembledHeader.shortPkt.frameNumber;
            state <= packetGap;
          end
          else
          begin
            wordCount_o <= assembledHeader.longPkt.wordCount;
            byteCount <= assembledHeader.longPkt.wordCount;
            // empty long packet carries no payload words
            if (assembledHeader.longPkt.wordCount == '0)
            begin
              state <= packetGap;
            end
            else
            begin
              state <= payload;
            end
          end
        end
        payload:
        begin
          payloadStrobe_o <= 1'b1;
          // odd counts end on a word with one valid byte
          if (byteCount <= headerFieldWidth'(bytesPerWord))
          begin
            packetLast_o <= 1'b1;
            byteCount <= '0;
            state <= packetGap;
          end
          else
          begin
            byteCount <= byteCount - headerFieldWidth'(bytesPerWord);
          end
        end
        default:
        begin
          state <= huntSync;
        end
      endcase
    end
  end

  // header and payload data registers
  always_ff @(posedge CAM_CLOCK_I)
  begin
    if (state == headerLow)
    begin
      headerLowWord <= laneWord_i;
    end
    if (state == payload)
    begin
      payloadWord_o <= laneWord_i;
    end
  end

endmodule

// File: hdl/streamOutput.sv
`timescale 1ns/1ps

module streamOutput
  import csiRxPkg::*;
(
  input  logic                        CAM_CLOCK_I,
  input  logic                        RESET_n_I,
  input  logic [laneWordWidth-1:0]    payloadWord_i,
  input  logic                        payloadStrobe_i,
  input  logic                        packetLast_i,
  input  logic                        frameActive_i,
  input  logic [headerFieldWidth-1:0] frameNumber_i,
  input  logic [headerFieldWidth-1:0] wordCount_i,
  output logic [laneWordWidth-1:0]    payloadData_o,
  output logic                        payloadValid_o,
  output logic                        lineStart_o,
  output logic                        lineEnd_o,
  output logic                        frameValid_o,
  output logic                        frameStart_o,
  output logic                        frameEnd_o,
  output logic [headerFieldWidth-1:0] frameNumber_o,
  output logic [headerFieldWidth-1:0] wordCount_o
);

  // set while a line has started but its last word is not yet seen
  logic inLine;

  always_ff @(posedge CAM_CLOCK_I)
  begin
    payloadData_o <= payloadWord_i;
  end

  always_ff @(posedge CAM_CLOCK_I)
  begin
    if (!RESET_n_I)
    begin
      inLine <= 1'b0;
      payloadValid_o <= 1'b0;
      lineStart_o <= 1'b0;
      lineEnd_o <= 1'b0;
      frameValid_o <= 1'b0;
      frameStart_o <= 1'b0;
      frameEnd_o <= 1'b0;
      frameNumber_o <= '0;
      wordCount_o <= wordCountReset;
    end
    else
    begin
      payloadValid_o <= payloadStrobe_i;
      lineStart_o <= payloadStrobe_i && !inLine;
      lineEnd_o <= payloadStrobe_i && packetLast_i;
      if (payloadStrobe_i)
      begin
        inLine <= !packetLast_i;
      end

      // frameValid_o still holds the previous level here
      frameValid_o <= frameActive_i;
      frameStart_o <= frameActive_i && !frameValid_o;
      frameEnd_o <= !frameActive_i && frameValid_o;

      frameNumber_o <= frameNumber_i;
      wordCount_o <= wordCount_i;
    end
  end

endmodule

// File: hdl/csiRxDecoder.sv
`timescale 1ns/1ps

module csiRxDecoder
  import csiRxPkg::*;
(
  input  logic                        CAM_CLOCK_I,
  input  logic                        RESET_n_I,
  input  logic [laneByteWidth-1:0]    laneA_i,
  input  logic [laneByteWidth-1:0]    laneB_i,
  output logic [laneWordWidth-1:0]    payloadData_o,
  output logic                        payloadValid_o,
  output logic                        lineStart_o,
  output logic                        lineEnd_o,
  output logic                        frameValid_o,
  output logic                        frameStart_o,
  output logic                        frameEnd_o,
  output logic [headerFieldWidth-1:0] frameNumber_o,
  output logic [headerFieldWidth-1:0] wordCount_o
);

  logic [laneWordWidth-1:0] laneWord;
  logic syncHit;
  logic [laneWordWidth-1:0] payloadWord;
  logic payloadStrobe;
  logic packetLast;
  logic frameActive;
  logic [headerFieldWidth-1:0] headerFrameNumber;
  logic [headerFieldWidth-1:0] headerWordCount;

  laneCapture captureInst (
    .CAM_CLOCK_I (CAM_CLOCK_I),
    .RESET_n_I   (RESET_n_I),
    .laneA_i     (laneA_i),
    .laneB_i     (laneB_i),
    .laneWord_o  (laneWord),
    .syncHit_o   (syncHit)
  );

  packetParser parserInst (
    .CAM_CLOCK_I     (CAM_CLOCK_I),
    .RESET_n_I       (RESET_n_I),
    .laneWord_i      (laneWord),
    .syncHit_i       (syncHit),
    .payloadWord_o   (payloadWord),
    .payloadStrobe_o (payloadStrobe),
    .packetLast_o    (packetLast),
    .frameActive_o   (frameActive),
    .frameNumber_o   (headerFrameNumber),
    .wordCount_o     (headerWordCount)
  );

  streamOutput outputInst (
    .CAM_CLOCK_I     (CAM_CLOCK_I),
    .RESET_n_I       (RESET_n_I),
    .payloadWord_i   (payloadWord),
    .payloadStrobe_i (payloadStrobe),
    .packetLast_i    (packetLast),
    .frameActive_i   (frameActive),
    .frameNumber_i   (headerFrameNumber),
    .wordCount_i     (headerWordCount),
    .payloadData_o   (payloadData_o),
    .payloadValid_o  (payloadValid_o),
    .lineStart_o     (lineStart_o),
    .lineEnd_o       (lineEnd_o),
    .frameValid_o    (frameValid_o),
    .frameStart_o    (frameStart_o),
    .frameEnd_o      (frameEnd_o),
    .frameNumber_o   (frameNumber_o),
    .wordCount_o     (wordCount_o)
  );

endmodule

// File: testbench/tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen (
  output logic clock_o,
  output logic resetN_o
);

  // 10 ns period
  initial
  begin
    clock_o = 1'b0;
    forever
    begin
      #5 clock_o = ~clock_o;
    end
  end

  // reset held low over the first eight rising edges
  initial
  begin
    resetN_o = 1'b0;
    repeat (8)
    begin
      @(posedge clock_o);
    end
    #1 resetN_o = 1'b1;
  end

endmodule

// File: testbench/csiRxDecoder_sva.sv
`timescale 1ns/1ps

module csiRxDecoder_sva (
  input logic CAM_CLOCK_I,
  input logic RESET_n_I,
  input logic payloadValid_i,
  input logic lineStart_i,
  input logic lineEnd_i,
  input logic frameValid_i,
  input logic frameStart_i,
  input logic frameEnd_i
);

  // line markers ride on valid payload words only
  lineFlagsNeedValid: assert property (
    @(posedge CAM_CLOCK_I) disable iff (!RESET_n_I)
    (lineStart_i || lineEnd_i) |-> payloadValid_i
  ) else $error("line flag without a valid payload word");

  frameEdgesExclusive: assert property (
    @(posedge CAM_CLOCK_I) disable iff (!RESET_n_I)
    !(frameStart_i && frameEnd_i)
  ) else $error("frame start and frame end in the same cycle");

  // frame valid is already high in the cycle of the start pulse
  frameStartSetsValid: assert property (
    @(posedge CAM_CLOCK_I) disable iff (!RESET_n_I)
    frameStart_i |-> frameValid_i
  ) else $error("frame start pulse without frame valid");

endmodule

bind streamOutput csiRxDecoder_sva outputChecks (
  .CAM_CLOCK_I    (CAM_CLOCK_I),
  .RESET_n_I      (RESET_n_I),
  .payloadValid_i (payloadValid_o),
  .lineStart_i    (lineStart_o),
  .lineEnd_i      (lineEnd_o),
  .frameValid_i   (frameValid_o),
  .frameStart_i   (frameStart_o),
  .frameEnd_i     (frameEnd_o)
);

// File: testbench/csiRxDecoder_tb.sv
`timescale 1ns/1ps

module csiRxDecoder_tb
  import csiRxPkg::*;
();

  logic clock;
  logic resetN;
  logic [laneByteWidth-1:0] laneA;
  logic [laneByteWidth-1:0] laneB;
  logic [laneWordWidth-1:0] payloadData;
  logic payloadValid;
  logic lineStart;
  logic lineEnd;
  logic frameValid;
  logic frameStart;
  logic frameEnd;
  logic [headerFieldWidth-1:0] frameNumber;
  logic [headerFieldWidth-1:0] wordCount;

  int seed;
  int cycleCount = 0;
  int frameStartCount = 0;
  int frameEndCount = 0;
  int frameStartCycle = -1;
  int frameEndCycle = -1;
  int frameRiseCycle = -1;
  int frameFallCycle = -1;
  logic frameValidLast = 1'b0;

  // words seen on the output, and the words a test expects
  logic [laneWordWidth-1:0] gotData[$];
  logic gotStart[$];
  logic gotEnd[$];
  int gotCycle[$];
  logic [laneWordWidth-1:0] expData[$];
  logic expStart[$];
  logic expEnd[$];

  tbClockGen clockGen (
    .clock_o  (clock),
    .resetN_o (resetN)
  );

  csiRxDecoder csiRxDecoder_inst (
    .CAM_CLOCK_I    (clock),
    .RESET_n_I      (resetN),
    .laneA_i        (laneA),
    .laneB_i        (laneB),
    .payloadData_o  (payloadData),
    .payloadValid_o (payloadValid),
    .lineStart_o    (lineStart),
    .lineEnd_o      (lineEnd),
    .frameValid_o   (frameValid),
    .frameStart_o   (frameStart),
    .frameEnd_o     (frameEnd),
    .frameNumber_o  (frameNumber),
    .wordCount_o    (wordCount)
  );

  always @(posedge clock)
  begin
    cycleCount <= cycleCount + 1;
  end

  // outputs are collected mid-cycle where they are stable
  always @(negedge clock)
  begin
    if (resetN)
    begin
      if (payloadValid)
      begin
        gotData.push_back(payloadData);
        gotStart.push_back(lineStart);
        gotEnd.push_back(lineEnd);
        gotCycle.push_back(cycleCount);
      end
      if (frameStart)
      begin
        frameStartCount++;
        frameStartCycle = cycleCount;
      end
      if (frameEnd)
      begin
        frameEndCount++;
        frameEndCycle = cycleCount;
      end
      if (frameValid && !frameValidLast)
      begin
        frameRiseCycle = cycleCount;
      end
      if (!frameValid && frameValidLast)
      begin
        frameFallCycle = cycleCount;
      end
      frameValidLast = frameValid;
    end
  end

  task automatic abortRun();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic showMismatch(input string message);
    $display("MISMATCH at %0t ns: %s", $time, message);
    abortRun();
  endtask

  task automatic failPlainly(input string message);
    $display("%s", message);
    abortRun();
  endtask

  function automatic logic [laneByteWidth-1:0] idleByte();
    logic [laneByteWidth-1:0] value;
    value = laneByteWidth'($random(seed));
    // idle traffic never carries the sync byte
    if (value == syncByte)
    begin
      value = ~syncByte;
    end
    return value;
  endfunction

  task automatic driveWord(input logic [laneByteWidth-1:0] lowByte,
                           input logic [laneByteWidth-1:0] highByte);
    @(posedge clock);
    #1;
    laneA = lowByte;
    laneB = highByte;
  endtask

  task automatic driveIdle(input int cycles);
    repeat (cycles)
    begin
      driveWord(idleByte(), idleByte());
    end
  endtask

  task automatic sendShortPacket(input logic [dataTypeWidth-1:0] dataType,
                                 input logic [15:0] field, output int headerCycle);
    driveWord(syncByte, syncByte);
    driveWord({2'b00, dataType}, field[7:0]);
    headerCycle = cycleCount;
    // ECC byte is not checked by the receiver
    driveWord(field[15:8], idleByte());
  endtask

  task automatic sendLongPacket(input logic [15:0] sentCount, output int firstCycle);
    int total;
    logic [laneByteWidth-1:0] lowByte;
    logic [laneByteWidth-1:0] highByte;
    total = (int'(sentCount) + 1) / 2;
    driveWord(syncByte, syncByte);
    // data type 0x2A, one RAW8 line
    driveWord(8'h2A, sentCount[7:0]);
    driveWord(sentCount[15:8], idleByte());
    for (int i = 0; i < total; i++)
    begin
      lowByte = laneByteWidth'($random(seed));
      highByte = laneByteWidth'($random(seed));
      driveWord(lowByte, highByte);
      if (i == 0)
      begin
        firstCycle = cycleCount;
      end
      expData.push_back({highByte, lowByte});
      expStart.push_back(i == 0);
      expEnd.push_back(i == total - 1);
    end
  endtask

  task automatic checkStream(input int startIndex, input int firstCycle);
    int waited;
    int index;
    waited = 0;
    while (gotData.size() - startIndex < expData.size() && waited < 64)
    begin
      driveIdle(1);
      waited++;
    end
    if (gotData.size() - startIndex < expData.size())
    begin
      failPlainly("timeout while waiting for payload words on the output");
    end
    // extra cycles so that a surplus word would show up
    driveIdle(4);
    assert (gotData.size() - startIndex == expData.size())
    else showMismatch($sformatf("expected %0d payload words, got %0d",
                                expData.size(), gotData.size() - startIndex));
    assert (gotCycle[startIndex] == firstCycle + 3)
    else showMismatch($sformatf("first word at cycle %0d, expected cycle %0d",
                                gotCycle[startIndex], firstCycle + 3));
    for (int i = 0; i < expData.size(); i++)
    begin
      index = startIndex + i;
      assert (gotData[index] == expData[i])
      else showMismatch($sformatf("word %0d is %h, expected %h", i, gotData[index], expData[i]));
      assert (gotStart[index] == expStart[i] && gotEnd[index] == expEnd[i])
      else showMismatch($sformatf("word %0d line flags start %b end %b, expected %b %b",
                                  i, gotStart[index], gotEnd[index], expStart[i], expEnd[i]));
    end
  endtask

  task automatic checkReset();
    for (int i = 0; i < 6; i++)
    begin
      driveIdle(1);
      assert (!payloadValid && !lineStart && !lineEnd && !frameStart && !frameEnd && !frameValid)
      else showMismatch("a strobe or frameValid_o is high after reset");
      assert (wordCount == wordCountReset && frameNumber == '0)
      else showMismatch($sformatf("after reset wordCount_o %h frameNumber_o %h",
                                  wordCount, frameNumber));
    end
  endtask

  task automatic checkFrameStart(input logic [15:0] sentNumber);
    int headerCycle;
    int startsBefore;
    int waited;
    startsBefore = frameStartCount;
    sendShortPacket(dtFrameStart, sentNumber, headerCycle);
    waited = 0;
    while (!frameValid && waited < 16)
    begin
      driveIdle(1);
      waited++;
    end
    if (!frameValid)
    begin
      failPlainly("timeout while waiting for frameValid_o to rise");
    end
    driveIdle(3);
    assert (frameStartCount - startsBefore == 1)
    else showMismatch($sformatf("%0d frame start pulses, expected 1",
                                frameStartCount - startsBefore));
    assert (frameRiseCycle == headerCycle + 3)
    else showMismatch($sformatf("frameValid_o rose at cycle %0d, expected %0d",
                                frameRiseCycle, headerCycle + 3));
    // the pulse marks the cycle in which the level changes
    assert (frameStartCycle == headerCycle + 3)
    else showMismatch($sformatf("frameStart_o at cycle %0d, expected %0d",
                                frameStartCycle, headerCycle + 3));
    assert (frameValid && frameNumber == sentNumber)
    else showMismatch($sformatf("frameNumber_o %h, expected %h", frameNumber, sentNumber));
  endtask

  task automatic checkLongPacket(input logic [15:0] sentCount);
    int startIndex;
    int firstCycle;
    expData.delete();
    expStart.delete();
    expEnd.delete();
    startIndex = gotData.size();
    sendLongPacket(sentCount, firstCycle);
    checkStream(startIndex, firstCycle);
    assert (wordCount == sentCount)
    else showMismatch($sformatf("wordCount_o %h, expected %h", wordCount, sentCount));
  endtask

  task automatic checkBackToBack();
    int startIndex;
    int firstCycle;
    int secondCycle;
    expData.delete();
    expStart.delete();
    expEnd.delete();
    startIndex = gotData.size();
    sendLongPacket(16'd6, firstCycle);
    sendLongPacket(16'd5, secondCycle);
    checkStream(startIndex, firstCycle);
    assert (gotCycle[startIndex + 3] == secondCycle + 3)
    else showMismatch("second packet's first word is not 3 cycles after it was driven");
    assert (wordCount == 16'd5)
    else showMismatch($sformatf("wordCount_o %h after second packet, expected 0005", wordCount));
  endtask

  task automatic checkFrameEnd();
    int headerCycle;
    int endsBefore;
    int startIndex;
    int waited;
    endsBefore = frameEndCount;
    startIndex = gotData.size();
    sendShortPacket(dtFrameEnd, 16'($random(seed)), headerCycle);
    waited = 0;
    while (frameValid && waited < 16)
    begin
      driveIdle(1);
      waited++;
    end
    if (frameValid)
    begin
      failPlainly("timeout while waiting for frameValid_o to fall");
    end
    driveIdle(4);
    assert (frameEndCount - endsBefore == 1)
    else showMismatch($sformatf("%0d frame end pulses, expected 1", frameEndCount - endsBefore));
    assert (frameFallCycle == headerCycle + 3)
    else showMismatch($sformatf("frameValid_o fell at cycle %0d, expected %0d",
                                frameFallCycle, headerCycle + 3));
    assert (frameEndCycle == headerCycle + 3)
    else showMismatch($sformatf("frameEnd_o at cycle %0d, expected %0d",
                                frameEndCycle, headerCycle + 3));
    assert (gotData.size() == startIndex)
    else showMismatch("payload words appeared for a frame end packet");
  endtask

  initial
  begin
    int waited;
    seed = 32'ha663971f;
    laneA = 8'h00;
    laneB = 8'h00;
    waited = 0;
    while (!resetN && waited < 20)
    begin
      @(posedge clock);
      waited++;
    end
    if (!resetN)
    begin
      failPlainly("reset was never released");
    end
    checkReset();
    checkFrameStart(16'($random(seed)));
    checkLongPacket(16'd8);
    checkLongPacket(16'd7);
    checkBackToBack();
    checkFrameEnd();
    driveIdle(4);
    // every failed check has already stopped the run
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: csiRxDecoder.f
hdl/csiRxPkg.sv
hdl/laneCapture.sv
hdl/packetParser.sv
hdl/streamOutput.sv
hdl/csiRxDecoder.sv
testbench/tbClockGen.sv
testbench/csiRxDecoder_sva.sv
testbench/csiRxDecoder_tb.sv

// File: Makefile
# Verilator build and run of the CSI-2 receive decoder testbench

VERILATOR ?= verilator
TOP       ?= csiRxDecoder_tb
FILELIST  ?= csiRxDecoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= NO ERRORS
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT JOBS VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
